/* hdl/id_cfg.svh */
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// datapath widths
`define ID_XLEN     32
`define ID_RADDR_W  5
`define ID_NREGS    32

// addi x0, x0, 0
`define ID_NOP_IR   32'h0000_0013

// pc carried by bubbles, word aligned and outside normal code
`define ID_NOP_PC   32'hffff_fffc

`endif

/* hdl/id_pkg.sv */
`include "id_cfg.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0]    word_t;
    typedef logic [`ID_RADDR_W-1:0] regaddr_t;

    // rv32i major opcodes, system falls through to halt
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_IMM      = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP          = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111
    } opcode_t;

    // {funct7[0], funct7[5], funct3}
    typedef enum logic [4:0] {
        ALU_ADD   = 5'b00000,
        ALU_SLL   = 5'b00001,
        ALU_SLT   = 5'b00010,
        ALU_SLTU  = 5'b00011,
        ALU_XOR   = 5'b00100,
        ALU_SRL   = 5'b00101,
        ALU_OR    = 5'b00110,
        ALU_AND   = 5'b00111,
        ALU_SUB   = 5'b01000,
        ALU_SRA   = 5'b01101,
        ALU_COPY1 = 5'b11110,
        ALU_X     = 5'b11111
    } alu_mode_t;

    typedef enum logic [1:0] {MA_X, MA_LOAD, MA_STORE} ma_mode_t;

    // same encoding as funct3 of loads and stores
    typedef enum logic [2:0] {
        MA_SIZE_B  = 3'b000,
        MA_SIZE_H  = 3'b001,
        MA_SIZE_W  = 3'b010,
        MA_SIZE_X  = 3'b011,
        MA_SIZE_BU = 3'b100,
        MA_SIZE_HU = 3'b101
    } ma_size_t;

    typedef enum logic [1:0] {WB_SRC_X, WB_SRC_ALU, WB_SRC_MEM, WB_SRC_PC4} wb_src_t;
    typedef enum logic [1:0] {PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH} pc_mode_t;
    typedef enum logic [1:0] {ALU_OP1_RS1, ALU_OP1_IMMU, ALU_OP1_X} op1_sel_t;
    typedef enum logic [2:0] {
        ALU_OP2_RS2, ALU_OP2_IMMI, ALU_OP2_IMMS, ALU_OP2_PC, ALU_OP2_X
    } op2_sel_t;

    typedef struct packed {
        logic      halt;
        pc_mode_t  pc_mode;
        op1_sel_t  op1_sel;
        op2_sel_t  op2_sel;
        alu_mode_t alu_mode;
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        wb_src_t   wb_src;
        logic      rs1_used;
        logic      rs2_used;
    } ctrl_t;

    typedef struct packed {
        word_t i;
        word_t s;
        word_t b;
        word_t u;
        word_t j;
    } imm_t;

    typedef struct packed {
        logic     valid;
        logic     ready;  // data already computed
        regaddr_t addr;
        word_t    data;
    } stage_fwd_t;

    typedef struct packed {
        logic     valid;
        regaddr_t addr;
        word_t    data;
    } wb_write_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
    } redirect_t;

    typedef struct packed {
        word_t     pc;
        word_t     ir;
        word_t     alu_op1;
        word_t     alu_op2;
        alu_mode_t alu_mode;
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        word_t     ma_data;  // store data
        wb_src_t   wb_src;
        word_t     wb_data;  // link address
        logic      wb_valid;
        logic      halt;
    } issue_t;

endpackage

/* hdl/id_decoder.sv */
`timescale 1ns/1ps

module id_decoder
    import id_pkg::*;
(
    input  word_t      ir_i,
    output ctrl_t      ctrl_o,
    output imm_t       imm_o,
    output regaddr_t   rs1_o,
    output regaddr_t   rs2_o,
    output regaddr_t   rd_o,
    output logic [2:0] funct3_o
);

    opcode_t    opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    alu_mode_t  alu_mode3;  // immediate ops, funct3 only
    alu_mode_t  alu_mode7;  // register ops and srai

    always_comb begin
        opcode = opcode_t'(ir_i[6:0]);
        funct3 = ir_i[14:12];
        funct7 = ir_i[31:25];

        alu_mode7 = alu_mode_t'({funct7[0], funct7[5], funct3});
        alu_mode3 = alu_mode_t'({2'b00, funct3});
    end

    assign rd_o     = ir_i[11:7];
    assign rs1_o    = ir_i[19:15];
    assign rs2_o    = ir_i[24:20];
    assign funct3_o = funct3;

    // sign extended immediates for every format
    always_comb begin
        imm_o.i = {{21{ir_i[31]}}, ir_i[30:20]};
        imm_o.s = {{21{ir_i[31]}}, ir_i[30:25], ir_i[11:7]};
        imm_o.b = {{20{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
        imm_o.u = {ir_i[31:12], 12'b0};
        imm_o.j = {{12{ir_i[31]}}, ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
    end

    // first match wins, shift right immediates ahead of the rest of OP_IMM
    always_comb begin
        casez ({funct7, funct3, opcode})
            {7'b0?00000, 3'b101, OP_IMM}:
                ctrl_o = '{1'b0, PC_NEXT, ALU_OP1_RS1, ALU_OP2_IMMI, alu_mode7,
                           MA_X, MA_SIZE_X, WB_SRC_ALU, 1'b1, 1'b0};
            {7'b???????, 3'b???, OP_IMM}:
                ctrl_o = '{1'b0, PC_NEXT, ALU_OP1_RS1, ALU_OP2_IMMI, alu_mode3,
                           MA_X, MA_SIZE_X, WB_SRC_ALU, 1'b1, 1'b0};
            {7'b???????, 3'b???, OP_LUI}:
                ctrl_o = '{1'b0, PC_NEXT, ALU_OP1_IMMU, ALU_OP2_X, ALU_COPY1,
                           MA_X, MA_SIZE_X, WB_SRC_ALU, 1'b0, 1'b0};
            {7'b???????, 3'b???, OP_AUIPC}:
                ctrl_o = '{1'b0, PC_NEXT, ALU_OP1_IMMU, ALU_OP2_PC, ALU_ADD,
                           MA_X, MA_SIZE_X, WB_SRC_ALU, 1'b0, 1'b0};
            {7'b???????, 3'b???, OP}:
                ctrl_o = '{1'b0, PC_NEXT, ALU_OP1_RS1, ALU_OP2_RS2, alu_mode7,
                           MA_X, MA_SIZE_X, WB_SRC_ALU, 1'b1, 1'b1};
            {7'b???????, 3'b???, OP_JAL}:
                ctrl_o = '{1'b0, PC_JUMP_REL, ALU_OP1_X, ALU_OP2_X, ALU_X,
                           MA_X, MA_SIZE_X, WB_SRC_PC4, 1'b0, 1'b0};
            {7'b???????, 3'b???, OP_JALR}:
                ctrl_o = '{1'b0, PC_JUMP_ABS, ALU_OP1_X, ALU_OP2_X, ALU_X,
                           MA_X, MA_SIZE_X, WB_SRC_PC4, 1'b1, 1'b0};
            {7'b???????, 3'b00?, OP_BRANCH},   // beq, bne
            {7'b???????, 3'b1??, OP_BRANCH}:   // blt, bge, bltu, bgeu
                ctrl_o = '{1'b0, PC_BRANCH, ALU_OP1_X, ALU_OP2_X, ALU_X,
                           MA_X, MA_SIZE_X, WB_SRC_X, 1'b1, 1'b1};
            {7'b???????, 3'b???, OP_LOAD}:
                ctrl_o = '{1'b0, PC_NEXT, ALU_OP1_RS1, ALU_OP2_IMMI, ALU_ADD,
                           MA_LOAD, ma_size_t'(funct3), WB_SRC_MEM, 1'b1, 1'b0};
            {7'b???????, 3'b???, OP_STORE}:
                ctrl_o = '{1'b0, PC_NEXT, ALU_OP1_RS1, ALU_OP2_IMMS, ALU_ADD,
                           MA_STORE, ma_size_t'(funct3), WB_SRC_X, 1'b1, 1'b1};
            {7'b???????, 3'b???, OP_MISC_MEM}:  // fence is a nop here
                ctrl_o = '{1'b0, PC_NEXT, ALU_OP1_X, ALU_OP2_X, ALU_X,
                           MA_X, MA_SIZE_X, WB_SRC_X, 1'b0, 1'b0};
            default:  // system and anything unknown
                ctrl_o = '{1'b1, PC_NEXT, ALU_OP1_X, ALU_OP2_X, ALU_X,
                           MA_X, MA_SIZE_X, WB_SRC_X, 1'b0, 1'b0};
        endcase
    end

endmodule

/* hdl/id_regfile.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module id_regfile
    import id_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  regaddr_t  rd_addr_a_i,
    input  regaddr_t  rd_addr_b_i,
    output word_t     rd_data_a_o,
    output word_t     rd_data_b_o,
    input  wb_write_t wr_i
);

    word_t regs_q [1:`ID_NREGS-1];  // x0 has no storage

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `ID_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.valid && wr_i.addr != '0) begin
            regs_q[wr_i.addr] <= wr_i.data;
        end
    end

    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs_q[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs_q[rd_addr_b_i];

    // write-back stage must never target x0
    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_i.valid |-> wr_i.addr != '0);

endmodule

/* hdl/id_forward.sv */
`timescale 1ns/1ps

module id_forward
    import id_pkg::*;
(
    input  regaddr_t   rs1_i,
    input  regaddr_t   rs2_i,
    input  logic       rs1_used_i,
    input  logic       rs2_used_i,
    input  word_t      rf_a_i,
    input  word_t      rf_b_i,
    input  stage_fwd_t ex_i,
    input  stage_fwd_t ma_i,
    input  wb_write_t  wb_i,
    output word_t      op_a_o,
    output word_t      op_b_o,
    output logic       hazard_o
);

    // youngest producer wins
    function automatic word_t fwd_value(regaddr_t addr, word_t rf_data);
        if (ex_i.valid && ex_i.addr == addr)
            return ex_i.data;
        else if (ma_i.valid && ma_i.addr == addr)
            return ma_i.data;
        else if (wb_i.valid && wb_i.addr == addr)
            return wb_i.data;
        return rf_data;
    endfunction

    // result on its way but not computed yet
    function automatic logic collides(regaddr_t addr, logic used);
        logic ex_hit;
        logic ma_hit;
        ex_hit = ex_i.valid && ex_i.addr == addr && !ex_i.ready;
        ma_hit = ma_i.valid && ma_i.addr == addr && !ma_i.ready;
        return used && addr != '0 && (ex_hit || ma_hit);
    endfunction

    assign op_a_o = fwd_value(rs1_i, rf_a_i);
    assign op_b_o = fwd_value(rs2_i, rf_b_i);

    always_comb begin
        hazard_o = collides(rs1_i, rs1_used_i) || collides(rs2_i, rs2_used_i);

        // producers never report x0, so an x0 operand always forwards as zero
        a_no_x0_producer: assert (!(ex_i.valid && ex_i.addr == '0)
                                  && !(ma_i.valid && ma_i.addr == '0))
            else $error("ex or ma reported a result for x0");
    end

endmodule

/* hdl/id_branch.sv */
`timescale 1ns/1ps

module id_branch
    import id_pkg::*;
(
    input  ctrl_t      ctrl_i,
    input  imm_t       imm_i,
    input  logic [2:0] funct3_i,
    input  word_t      pc_i,
    input  word_t      op_a_i,
    input  word_t      op_b_i,
    input  logic       hazard_i,
    output redirect_t  redirect_o
);

    logic cond;
    logic taken;

    always_comb begin
        case (funct3_i[2:1])
            2'b00:   cond = op_a_i == op_b_i;                    // beq
            2'b10:   cond = signed'(op_a_i) < signed'(op_b_i);   // blt
            2'b11:   cond = op_a_i < op_b_i;                     // bltu
            default: cond = 1'b0;
        endcase
        taken = cond ^ funct3_i[0];  // bne, bge, bgeu
    end

    // operands are not trusted while stalled
    always_comb begin
        case (ctrl_i.pc_mode)
            PC_JUMP_REL: redirect_o = '{1'b1, pc_i + imm_i.j};
            PC_JUMP_ABS: redirect_o = '{!hazard_i, op_a_i + imm_i.i};
            PC_BRANCH:   redirect_o = '{taken && !hazard_i, pc_i + imm_i.b};
            default:     redirect_o = '{1'b0, '0};
        endcase
    end

endmodule

/* hdl/id_issue_reg.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module id_issue_reg
    import id_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  word_t    pc_i,
    input  word_t    ir_i,
    input  ctrl_t    ctrl_i,
    input  imm_t     imm_i,
    input  regaddr_t rd_i,
    input  word_t    op_a_i,
    input  word_t    op_b_i,
    input  logic     hazard_i,
    output issue_t   issue_o
);

    // addi x0, x0, 0 with nothing written back
    localparam issue_t BUBBLE = '{`ID_NOP_PC, `ID_NOP_IR, '0, '0, ALU_ADD, MA_X,
                                  MA_SIZE_W, '0, WB_SRC_ALU, '0, 1'b0, 1'b0};

    word_t  alu_op1;
    word_t  alu_op2;
    issue_t issue_d;

    always_comb begin
        case (ctrl_i.op1_sel)
            ALU_OP1_RS1:  alu_op1 = op_a_i;
            ALU_OP1_IMMU: alu_op1 = imm_i.u;
            default:      alu_op1 = '0;
        endcase

        case (ctrl_i.op2_sel)
            ALU_OP2_RS2:  alu_op2 = op_b_i;
            ALU_OP2_IMMI: alu_op2 = imm_i.i;
            ALU_OP2_IMMS: alu_op2 = imm_i.s;
            ALU_OP2_PC:   alu_op2 = pc_i;
            default:      alu_op2 = '0;
        endcase
    end

    always_comb begin
        issue_d = '{pc_i, ir_i, alu_op1, alu_op2, ctrl_i.alu_mode, ctrl_i.ma_mode,
                    ctrl_i.ma_size, op_b_i, ctrl_i.wb_src, pc_i + 32'd4,
                    (ctrl_i.wb_src != WB_SRC_X) && (rd_i != '0), ctrl_i.halt};
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i)
            issue_o <= BUBBLE;
        else if (hazard_i)
            issue_o <= BUBBLE;  // stall, decode again next cycle
        else
            issue_o <= issue_d;
    end

    // a halting instruction reaches execute with no side effects
    a_halt_inert: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_o.halt |-> !issue_o.wb_valid && issue_o.ma_mode == MA_X);

endmodule

/* hdl/id_stage.sv */
`timescale 1ns/1ps

module id_stage
    import id_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  word_t      pc_i,
    input  word_t      ir_i,
    input  stage_fwd_t ex_fwd_i,
    input  stage_fwd_t ma_fwd_i,
    input  wb_write_t  wb_i,
    output logic       ready_o,
    output redirect_t  redirect_o,
    output issue_t     issue_o
);

    ctrl_t      ctrl;
    imm_t       imm;
    regaddr_t   rs1;
    regaddr_t   rs2;
    regaddr_t   rd;
    logic [2:0] funct3;
    word_t      rf_a;
    word_t      rf_b;
    word_t      op_a;  // forwarded operands
    word_t      op_b;
    logic       hazard;

    id_decoder u_decoder (
        .ir_i     (ir_i),
        .ctrl_o   (ctrl),
        .imm_o    (imm),
        .rs1_o    (rs1),
        .rs2_o    (rs2),
        .rd_o     (rd),
        .funct3_o (funct3)
    );

    id_regfile u_regfile (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rd_addr_a_i (rs1),
        .rd_addr_b_i (rs2),
        .rd_data_a_o (rf_a),
        .rd_data_b_o (rf_b),
        .wr_i        (wb_i)
    );

    id_forward u_forward (
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_used_i (ctrl.rs1_used),
        .rs2_used_i (ctrl.rs2_used),
        .rf_a_i     (rf_a),
        .rf_b_i     (rf_b),
        .ex_i       (ex_fwd_i),
        .ma_i       (ma_fwd_i),
        .wb_i       (wb_i),
        .op_a_o     (op_a),
        .op_b_o     (op_b),
        .hazard_o   (hazard)
    );

    id_branch u_branch (
        .ctrl_i     (ctrl),
        .imm_i      (imm),
        .funct3_i   (funct3),
        .pc_i       (pc_i),
        .op_a_i     (op_a),
        .op_b_i     (op_b),
        .hazard_i   (hazard),
        .redirect_o (redirect_o)
    );

    id_issue_reg u_issue_reg (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .pc_i     (pc_i),
        .ir_i     (ir_i),
        .ctrl_i   (ctrl),
        .imm_i    (imm),
        .rd_i     (rd),
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .hazard_i (hazard),
        .issue_o  (issue_o)
    );

    assign ready_o = !hazard;  // fetch holds the instruction while stalled

endmodule

/* verif/id_stage_tb.sv */
`timescale 1ns/1ps
`include "id_cfg.svh"

module id_stage_tb
    import id_pkg::*;
();

    localparam int RST_CYCLES = 3;

    // one row: stimulus, then expected responses
    typedef struct packed {
        word_t      pc;
        word_t      ir;
        stage_fwd_t ex;
        stage_fwd_t ma;
        wb_write_t  wb;
        logic       ready;
        logic       redir_valid;
        word_t      redir_addr;   // only compared when a redirect is expected
        word_t      op1;
        word_t      op2;
        logic       wb_valid;
        logic       halt;
    } vec_t;

    logic       clk_i;
    logic       rst_n_i;
    word_t      pc_i;
    word_t      ir_i;
    stage_fwd_t ex_fwd_i;
    stage_fwd_t ma_fwd_i;
    wb_write_t  wb_i;
    logic       ready_o;
    redirect_t  redirect_o;
    issue_t     issue_o;

    vec_t vecs[$];
    logic table_ready = 1'b0;
    int   n_errors = 0;
    int   n_rows = 0;
    int   cycles = 0;
    int   limit;

    id_stage u_id_stage (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .pc_i       (pc_i),
        .ir_i       (ir_i),
        .ex_fwd_i   (ex_fwd_i),
        .ma_fwd_i   (ma_fwd_i),
        .wb_i       (wb_i),
        .ready_o    (ready_o),
        .redirect_o (redirect_o),
        .issue_o    (issue_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // instruction encoders, straight from the rv32i formats
    function automatic word_t enc_i(logic [11:0] imm, regaddr_t rs1, logic [2:0] f3,
                                    regaddr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_r(regaddr_t rs2, regaddr_t rs1, regaddr_t rd);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};  // add
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, regaddr_t rs2, regaddr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, regaddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic stage_fwd_t fwd(regaddr_t addr, word_t data, logic rdy);
        return '{1'b1, rdy, addr, data};
    endfunction

    function automatic wb_write_t wbw(regaddr_t addr, word_t data);
        return '{1'b1, addr, data};
    endfunction

    task automatic add_row(word_t pc, word_t ir, stage_fwd_t ex, stage_fwd_t ma,
                           wb_write_t wb, logic rdy, logic rv, word_t ra,
                           word_t op1, word_t op2, logic wbv, logic halt);
        vec_t row;
        row = '{pc, ir, ex, ma, wb, rdy, rv, ra, op1, op2, wbv, halt};
        vecs.push_back(row);
    endtask

    task automatic report_mismatch(string sig, logic [31:0] exp, logic [31:0] act);
        n_errors++;
        $display("** Error at %0t: %s expected 0x%08h, actual 0x%08h", $time, sig, exp, act);
    endtask

    task automatic build_table();
        stage_fwd_t nf;
        wb_write_t  nw;
        nf = '0;
        nw = '0;
        add_row(32'h000, `ID_NOP_IR, nf, nf, wbw(5, 32'h1234_5678),
                1, 0, 0, 32'h0, 32'h0, 0, 0);                             // write x5
        add_row(32'h100, enc_i(12'hffd, 5, 3'b000, 6, OP_IMM), nf, nf, nw,
                1, 0, 0, 32'h1234_5678, 32'hffff_fffd, 1, 0);             // addi x6,x5,-3
        add_row(32'h104, enc_r(0, 5, 7), fwd(5, 32'haaaa_0001, 1), fwd(5, 32'hbbbb_0002, 1),
                wbw(5, 32'hcccc_0003), 1, 0, 0, 32'haaaa_0001, 32'h0, 1, 0);
        add_row(32'h108, enc_r(0, 5, 7), nf, fwd(5, 32'hbbbb_0002, 1),
                wbw(5, 32'hcccc_0003), 1, 0, 0, 32'hbbbb_0002, 32'h0, 1, 0);
        add_row(32'h10c, enc_r(0, 5, 7), nf, nf, wbw(5, 32'hcccc_0003),
                1, 0, 0, 32'hcccc_0003, 32'h0, 1, 0);
        add_row(32'h110, enc_r(0, 5, 7), nf, nf, nw,
                1, 0, 0, 32'hcccc_0003, 32'h0, 1, 0);                     // from regfile
        add_row(32'h114, enc_r(6, 5, 8), fwd(5, 32'heeee_0000, 0), nf, nw,
                0, 0, 0, 32'h0, 32'h0, 0, 0);                             // load-use stall
        add_row(32'h200, enc_b(13'h010, 5, 5, 3'b000), fwd(5, 32'heeee_0000, 0), nf, nw,
                0, 0, 0, 32'h0, 32'h0, 0, 0);                             // beq held back
        add_row(32'h300, enc_j(21'h000800, 1), nf, nf, nw,
                1, 1, 32'h0000_0b00, 32'h0, 32'h0, 1, 0);                 // jal
        add_row(32'h400, enc_i(12'h01d, 5, 3'b000, 1, OP_JALR), nf, nf, nw,
                1, 1, 32'hcccc_0020, 32'h0, 32'h0, 1, 0);                 // jalr
        add_row(32'h500, enc_b(13'h020, 11, 10, 3'b000), fwd(10, 32'd5, 1), fwd(11, 32'd5, 1),
                nw, 1, 1, 32'h0000_0520, 32'h0, 32'h0, 0, 0);             // beq taken
        add_row(32'h504, enc_b(13'h020, 11, 10, 3'b001), fwd(10, 32'd5, 1), fwd(11, 32'd5, 1),
                nw, 1, 0, 0, 32'h0, 32'h0, 0, 0);                         // bne not taken
        add_row(32'h600, enc_b(13'h1ff0, 11, 10, 3'b100), fwd(10, 32'hffff_ffff, 1),
                fwd(11, 32'd1, 1), nw, 1, 1, 32'h0000_05f0, 32'h0, 32'h0, 0, 0);
        add_row(32'h604, enc_b(13'h1ff0, 11, 10, 3'b111), fwd(10, 32'hffff_ffff, 1),
                fwd(11, 32'd1, 1), nw, 1, 1, 32'h0000_05f4, 32'h0, 32'h0, 0, 0);
        add_row(32'h608, enc_b(13'h1ff0, 11, 10, 3'b100), fwd(10, 32'd1, 1),
                fwd(11, 32'hffff_ffff, 1), nw, 1, 0, 0, 32'h0, 32'h0, 0, 0);
        add_row(32'h60c, enc_b(13'h1ff0, 11, 10, 3'b111), fwd(10, 32'd1, 1),
                fwd(11, 32'hffff_ffff, 1), nw, 1, 0, 0, 32'h0, 32'h0, 0, 0);
        add_row(32'h700, 32'h0000_0073, nf, nf, nw,
                1, 0, 0, 32'h0, 32'h0, 0, 1);                             // ecall
        add_row(32'h704, 32'h0000_00ff, nf, nf, nw,
                1, 0, 0, 32'h0, 32'h0, 0, 1);                             // bad opcode
        add_row(32'h708, {20'habcde, 5'd9, 7'b0110111}, nf, nf, nw,
                1, 0, 0, 32'habcd_e000, 32'h0, 1, 0);                     // lui x9
    endtask

    // watchdog
    initial begin
        wait (table_ready);
        limit = vecs.size() + RST_CYCLES + 20;
        while (cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout after %0d cycles, the vector loop never finished", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        vec_t  v;
        word_t exp_ir;
        word_t exp_pc;
        rst_n_i  = 1'b0;
        pc_i     = '0;
        ir_i     = `ID_NOP_IR;
        ex_fwd_i = '0;
        ma_fwd_i = '0;
        wb_i     = '0;
        build_table();
        table_ready = 1'b1;

        repeat (RST_CYCLES) @(posedge clk_i);
        #2 rst_n_i = 1'b1;

        // reset leaves a bubble in the issue register
        if (issue_o.wb_valid !== 1'b0)
            report_mismatch("issue_o.wb_valid", 0, issue_o.wb_valid);
        if (issue_o.halt !== 1'b0)
            report_mismatch("issue_o.halt", 0, issue_o.halt);
        if (issue_o.ir !== `ID_NOP_IR)
            report_mismatch("issue_o.ir", `ID_NOP_IR, issue_o.ir);

        foreach (vecs[k]) begin
            v        = vecs[k];
            pc_i     = v.pc;
            ir_i     = v.ir;
            ex_fwd_i = v.ex;
            ma_fwd_i = v.ma;
            wb_i     = v.wb;

            @(negedge clk_i);  // combinational outputs settled
            if (ready_o !== v.ready)
                report_mismatch("ready_o", v.ready, ready_o);
            if (redirect_o.valid !== v.redir_valid)
                report_mismatch("redirect_o.valid", v.redir_valid, redirect_o.valid);
            if (v.redir_valid && redirect_o.addr !== v.redir_addr)
                report_mismatch("redirect_o.addr", v.redir_addr, redirect_o.addr);

            @(posedge clk_i);
            #1;
            exp_ir = v.ready ? v.ir : `ID_NOP_IR;  // stall bubble
            exp_pc = v.ready ? v.pc : `ID_NOP_PC;
            if (issue_o.alu_op1 !== v.op1)
                report_mismatch("issue_o.alu_op1", v.op1, issue_o.alu_op1);
            if (issue_o.alu_op2 !== v.op2)
                report_mismatch("issue_o.alu_op2", v.op2, issue_o.alu_op2);
            if (issue_o.wb_valid !== v.wb_valid)
                report_mismatch("issue_o.wb_valid", v.wb_valid, issue_o.wb_valid);
            if (issue_o.halt !== v.halt)
                report_mismatch("issue_o.halt", v.halt, issue_o.halt);
            if (issue_o.ir !== exp_ir)
                report_mismatch("issue_o.ir", exp_ir, issue_o.ir);
            if (issue_o.pc !== exp_pc)
                report_mismatch("issue_o.pc", exp_pc, issue_o.pc);
            n_rows++;
            #1;
        end

        $display("rows applied: %0d, errors: %0d", n_rows, n_errors);
        if (n_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+hdl
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_regfile.sv
hdl/id_forward.sv
hdl/id_branch.sv
hdl/id_issue_reg.sv
hdl/id_stage.sv
verif/id_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module id_stage_tb \
    -Mdir obj_dir -o id_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/id_stage_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
fi
exit 1
